// File: source/ghtPkg.sv
package ghtPkg;

    localparam int NUM_BANKS = 8;
    localparam int NUM_ROWS = 32;
    localparam int NUM_COLS = 256;

    // address slice and history as seen on the lookup port
    typedef logic [15:0] ipBitsT;
    typedef logic [7:0] histT;

    // hashed index with col in [15:8], bank in {[7:6],[0]} and row in [5:1]
    typedef logic [15:0] tableIdxT;

    typedef logic [2:0] bankIdT;
    typedef logic [4:0] rowIdT;
    typedef logic [7:0] colIdT;

    // upper bit set means predict taken
    typedef logic [1:0] counterT;

    typedef struct packed {
        ipBitsT ip;
        histT hist;
    } lookupReqT;

    typedef struct packed {
        tableIdxT idx;
        counterT counter;
    } updateReqT;

    typedef struct packed {
        logic en;
        logic clear;
        rowIdT row;
        colIdT col;
        counterT counter;
    } bankWriteT;

    function automatic tableIdxT hashIdx(lookupReqT req);
        return req.ip ^ {req.hist, 8'b0};
    endfunction

    function automatic bankIdT bankOf(tableIdxT idx);
        return {idx[7:6], idx[0]};
    endfunction

    function automatic rowIdT rowOf(tableIdxT idx);
        return idx[5:1];
    endfunction

    function automatic colIdT colOf(tableIdxT idx);
        return idx[15:8];
    endfunction

endpackage

// File: source/counterBank.sv
module counterBank
    import ghtPkg::*;
(
    input logic clk,
    input bankWriteT wr,
    input rowIdT rdRow,
    input colIdT rdCol,
    output counterT rdCounter
);

    // one row holds all counters sharing the same row bits
    counterT [NUM_COLS-1:0] rows [NUM_ROWS];

    counterT [NUM_COLS-1:0] rdRowData;

    always_ff @(posedge clk) begin
        if (wr.clear) begin
            rows[wr.row] <= '0;
        end else if (wr.en) begin
            rows[wr.row][wr.col] <= wr.counter;
        end
    end

    // row first, then the column mux
    always_comb begin
        rdRowData = rows[rdRow];
    end

    assign rdCounter = rdRowData[rdCol];

endmodule

// File: source/lookupStage.sv
module lookupStage
    import ghtPkg::*;
(
    input logic clk,
    input logic rst,
    input logic lookupValid,
    input logic lookupReady,
    input lookupReqT lookupReq,
    output rowIdT rdRow,
    output colIdT rdCol,
    input counterT [NUM_BANKS-1:0] bankCounters,
    output logic predValid,
    output counterT predCounter
);

    logic accept;
    lookupReqT reqQ;
    tableIdxT idx;
    bankIdT bankSel;

    assign accept = lookupValid && lookupReady;

    // request payload held until the next accepted lookup
    always_ff @(posedge clk) begin
        if (accept) begin
            reqQ <= lookupReq;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            predValid <= 1'b0;
        end else begin
            predValid <= accept;
        end
    end

    // hash of the registered request drives all banks at once
    assign idx = hashIdx(reqQ);
    assign rdRow = rowOf(idx);
    assign rdCol = colOf(idx);
    assign bankSel = bankOf(idx);

    // only the addressed bank's counter is used
    assign predCounter = bankCounters[bankSel];

endmodule

// File: source/updateScheduler.sv
module updateScheduler
    import ghtPkg::*;
(
    input logic clk,
    input logic rst,
    input logic upd0Valid,
    input logic upd1Valid,
    input updateReqT upd0Req,
    input updateReqT upd1Req,
    output logic upd0Ready,
    output logic upd1Ready,
    output logic initBusy,
    output bankWriteT [NUM_BANKS-1:0] bankWr
);

    typedef enum logic [1:0] {
        ST_SWEEP,
        ST_READY,
        ST_DRAIN
    } schedStateT;

    schedStateT state;
    rowIdT sweepRow;
    updateReqT saved;

    logic acc0;
    logic acc1;
    bankIdT bank0;
    bankIdT bank1;
    bankIdT bankSaved;
    logic conflict;

    function automatic bankWriteT toCmd(updateReqT req);
        bankWriteT cmd;
        cmd.en = 1'b1;
        cmd.clear = 1'b0;
        cmd.row = rowOf(req.idx);
        cmd.col = colOf(req.idx);
        cmd.counter = req.counter;
        return cmd;
    endfunction

    assign initBusy = (state == ST_SWEEP);
    assign upd0Ready = (state == ST_READY);
    assign upd1Ready = (state == ST_READY);

    assign acc0 = upd0Valid && upd0Ready;
    assign acc1 = upd1Valid && upd1Ready;
    assign bank0 = bankOf(upd0Req.idx);
    assign bank1 = bankOf(upd1Req.idx);
    assign bankSaved = bankOf(saved.idx);

    // a bank takes one write per cycle so port 1 yields
    assign conflict = acc0 && acc1 && (bank0 == bank1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_SWEEP;
            sweepRow <= '0;
        end else begin
            case (state)
                ST_SWEEP: begin
                    sweepRow <= sweepRow + 1'b1;
                    if (sweepRow == rowIdT'(NUM_ROWS - 1)) begin
                        state <= ST_READY;
                    end
                end
                ST_READY: begin
                    if (conflict) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    state <= ST_READY;
                end
                default: begin
                    state <= ST_SWEEP;
                end
            endcase
        end
    end

    // save buffer payload
    always_ff @(posedge clk) begin
        if (conflict) begin
            saved <= upd1Req;
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bankWr[b] = '0;
            case (state)
                ST_SWEEP: begin
                    bankWr[b].clear = 1'b1;
                    bankWr[b].row = sweepRow;
                end
                ST_DRAIN: begin
                    if (bankSaved == bankIdT'(b)) begin
                        bankWr[b] = toCmd(saved);
                    end
                end
                default: begin
                    // port 0 first so a same-bank port 1 falls to the buffer
                    if (acc0 && bank0 == bankIdT'(b)) begin
                        bankWr[b] = toCmd(upd0Req);
                    end else if (acc1 && bank1 == bankIdT'(b)) begin
                        bankWr[b] = toCmd(upd1Req);
                    end
                end
            endcase
        end
    end

endmodule

// File: source/ghtTop.sv
module ghtTop
    import ghtPkg::*;
(
    input logic clk,
    input logic rst,
    input logic lookupValid,
    output logic lookupReady,
    input lookupReqT lookupReq,
    output logic predValid,
    output counterT predCounter,
    input logic upd0Valid,
    input logic upd1Valid,
    output logic upd0Ready,
    output logic upd1Ready,
    input updateReqT upd0Req,
    input updateReqT upd1Req
);

    logic initBusy;
    bankWriteT [NUM_BANKS-1:0] bankWr;
    rowIdT rdRow;
    colIdT rdCol;
    counterT [NUM_BANKS-1:0] bankCounters;

    // no lookups until every row is cleared
    assign lookupReady = ~initBusy;

    updateScheduler u_sched (
        .clk(clk),
        .rst(rst),
        .upd0Valid(upd0Valid),
        .upd1Valid(upd1Valid),
        .upd0Req(upd0Req),
        .upd1Req(upd1Req),
        .upd0Ready(upd0Ready),
        .upd1Ready(upd1Ready),
        .initBusy(initBusy),
        .bankWr(bankWr)
    );

    lookupStage u_lookup (
        .clk(clk),
        .rst(rst),
        .lookupValid(lookupValid),
        .lookupReady(lookupReady),
        .lookupReq(lookupReq),
        .rdRow(rdRow),
        .rdCol(rdCol),
        .bankCounters(bankCounters),
        .predValid(predValid),
        .predCounter(predCounter)
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : genBank
        counterBank u_bank (
            .clk(clk),
            .wr(bankWr[g]),
            .rdRow(rdRow),
            .rdCol(rdCol),
            .rdCounter(bankCounters[g])
        );
    end

endmodule

// File: verif/ghtTop_sva.sv
module ghtTopSva
    import ghtPkg::*;
(
    input logic clk,
    input logic rst,
    input logic lookupValid,
    input logic lookupReady,
    input logic predValid,
    input logic upd0Valid,
    input logic upd1Valid,
    input logic upd0Ready,
    input logic upd1Ready,
    input updateReqT upd0Req,
    input updateReqT upd1Req
);
    timeunit 1ns;
    timeprecision 1ps;

    logic sameBankPair;

    // both ports accepted into one bank
    assign sameBankPair = upd0Valid && upd0Ready && upd1Valid && upd1Ready
        && upd0Req.idx[7:6] == upd1Req.idx[7:6] && upd0Req.idx[0] == upd1Req.idx[0];

    predClearedByReset: assert property (@(posedge clk) rst |=> !predValid)
        else $error("predValid high in the cycle after reset");

    readiesLowInReset: assert property (@(posedge clk)
        rst && $past(rst) |-> !lookupReady && !upd0Ready && !upd1Ready)
        else $error("a ready is high while reset is held");

    conflictStalls: assert property (@(posedge clk) disable iff (rst)
        sameBankPair |=> !upd0Ready && !upd1Ready)
        else $error("update readies high after a same-bank pair");

    predFollowsLookup: assert property (@(posedge clk) disable iff (rst)
        lookupValid && lookupReady |=> predValid)
        else $error("no prediction after an accepted lookup");

endmodule

bind ghtTop ghtTopSva u_sva (
    .clk(clk),
    .rst(rst),
    .lookupValid(lookupValid),
    .lookupReady(lookupReady),
    .predValid(predValid),
    .upd0Valid(upd0Valid),
    .upd1Valid(upd1Valid),
    .upd0Ready(upd0Ready),
    .upd1Ready(upd1Ready),
    .upd0Req(upd0Req),
    .upd1Req(upd1Req)
);

// File: verif/ghtTopTb.sv
module ghtTopTb
    import ghtPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst;
    logic lookupValid;
    logic lookupReady;
    lookupReqT lookupReq;
    logic predValid;
    counterT predCounter;
    logic upd0Valid;
    logic upd1Valid;
    logic upd0Ready;
    logic upd1Ready;
    updateReqT upd0Req;
    updateReqT upd1Req;

    // reference table, one entry per hashed index
    counterT model [65536];
    updateReqT pendingReq;
    logic pendingValid;
    logic expValid;
    counterT expCounter;
    string testName;
    int checks;
    int errors;
    int testStartErrors;
    logic aborted;

    ghtTop u_dut (.*);

    always #2 clk = ~clk;

    function automatic bankIdT bankNumber(tableIdxT idx);
        return {idx[7:6], idx[0]};
    endfunction

    task automatic checkEq(string name, int expected, int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic waitReady(bit forUpdate);
        int n;
        n = 0;
        while (!(forUpdate ? (upd0Ready && upd1Ready) : lookupReady) && n < 100) begin
            nextCycle();
            n++;
        end
        if (!(forUpdate ? (upd0Ready && upd1Ready) : lookupReady)) begin
            $display("%s: the DUT did not raise its ready within 100 cycles", testName);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic startTest(string name);
        testName = name;
        testStartErrors = errors;
    endtask

    task automatic endTest();
        repeat (2) nextCycle();
        if (errors == testStartErrors) begin
            $display("test %s: passed", testName);
        end else begin
            $display("test %s: failed, %0d mismatches", testName, errors - testStartErrors);
        end
    endtask

    // random history with the ip chosen so that the hash lands on idx
    task automatic lookupExpect(tableIdxT idx, counterT expected);
        waitReady(1'b0);
        lookupReq.hist = histT'($urandom());
        lookupReq.ip = idx ^ {lookupReq.hist, 8'h00};
        lookupValid = 1'b1;
        nextCycle();
        lookupValid = 1'b0;
        checkEq({testName, " predValid"}, 1, int'(predValid));
        checkEq({testName, " counter"}, int'(expected), int'(predCounter));
    endtask

    task automatic update(bit v0, tableIdxT idx0, counterT c0,
                          bit v1, tableIdxT idx1, counterT c1);
        waitReady(1'b1);
        upd0Valid = v0;
        upd0Req = '{idx: idx0, counter: c0};
        upd1Valid = v1;
        upd1Req = '{idx: idx1, counter: c1};
        nextCycle();
        upd0Valid = 1'b0;
        upd1Valid = 1'b0;
    endtask

    // model sees the writes of the coming edge before the lookup it accepts
    always @(negedge clk) begin : refModel
        logic sameBank;
        if (rst) begin
            for (int i = 0; i < 65536; i++) model[16'(i)] = '0;
            pendingValid = 1'b0;
            expValid = 1'b0;
        end else begin
            checkEq({testName, " predValid"}, int'(expValid), int'(predValid));
            if (expValid) checkEq({testName, " counter"}, int'(expCounter), int'(predCounter));
            if (pendingValid) model[pendingReq.idx] = pendingReq.counter;
            pendingValid = 1'b0;
            sameBank = bankNumber(upd0Req.idx) == bankNumber(upd1Req.idx);
            if (upd0Valid && upd0Ready) model[upd0Req.idx] = upd0Req.counter;
            if (upd1Valid && upd1Ready) begin
                if (upd0Valid && upd0Ready && sameBank) begin
                    pendingReq = upd1Req;
                    pendingValid = 1'b1;
                end else begin
                    model[upd1Req.idx] = upd1Req.counter;
                end
            end
            expValid = lookupValid && lookupReady;
            expCounter = model[lookupReq.ip ^ {lookupReq.hist, 8'h00}];
        end
    end

    task automatic clearedAfterInit();
        startTest("init");
        repeat (5) begin
            nextCycle();
            checkEq("init readies in reset", 0, int'(lookupReady || upd0Ready || upd1Ready));
        end
        rst = 1'b0;
        checkEq("init readies in sweep", 0, int'(lookupReady || upd0Ready || upd1Ready));
        waitReady(1'b1);
        for (int i = 0; i < 64; i++) lookupExpect(tableIdxT'($urandom()), 2'b00);
        endTest();
    endtask

    task automatic singleUpdates();
        tableIdxT idx;
        tableIdxT otherIdx;
        counterT ctr;
        counterT otherCtr;
        bit port1;
        startTest("single update");
        for (int r = 0; r < 16; r++) begin
            idx = tableIdxT'($urandom());
            ctr = counterT'($urandom_range(3, 1));
            port1 = 1'($urandom());
            // idle port carries other data so a wrong port select shows
            otherIdx = ~idx;
            otherCtr = ~ctr;
            if (port1) begin
                update(1'b0, otherIdx, otherCtr, 1'b1, idx, ctr);
            end else begin
                update(1'b1, idx, ctr, 1'b0, otherIdx, otherCtr);
            end
            lookupExpect(idx, ctr);
        end
        endTest();
    endtask

    task automatic pairedUpdates(bit sameBank, int rounds);
        tableIdxT idx0;
        tableIdxT idx1;
        counterT c0;
        counterT c1;
        startTest(sameBank ? "same-bank conflict" : "dual update");
        for (int r = 0; r < rounds; r++) begin
            idx0 = tableIdxT'($urandom());
            idx1 = (sameBank && r == 0) ? idx0 : tableIdxT'($urandom());
            idx1[0] = sameBank ? idx0[0] : ~idx0[0];
            if (sameBank) idx1[7:6] = idx0[7:6];
            c0 = counterT'($urandom());
            c1 = c0 ^ counterT'($urandom_range(3, 1));
            update(1'b1, idx0, c0, 1'b1, idx1, c1);
            checkEq({testName, " upd0Ready"}, int'(!sameBank), int'(upd0Ready));
            checkEq({testName, " upd1Ready"}, int'(!sameBank), int'(upd1Ready));
            lookupExpect(idx0, (idx0 == idx1) ? c1 : c0);
            lookupExpect(idx1, c1);
        end
        endTest();
    endtask

    // small index pool whose upper half shares banks with the lower half
    task automatic randomMix();
        tableIdxT pool [8];
        startTest("random mix");
        for (int i = 0; i < 8; i++) begin
            pool[3'(i)] = tableIdxT'($urandom());
            if (i >= 4) begin
                pool[3'(i)][7:6] = pool[3'(i - 4)][7:6];
                pool[3'(i)][0] = pool[3'(i - 4)][0];
            end
        end
        for (int c = 0; c < 2000; c++) begin
            lookupValid = 1'($urandom());
            lookupReq.hist = histT'($urandom());
            lookupReq.ip = pool[3'($urandom())] ^ {lookupReq.hist, 8'h00};
            upd0Valid = 1'($urandom());
            upd0Req = '{idx: pool[3'($urandom())], counter: counterT'($urandom())};
            upd1Valid = 1'($urandom());
            upd1Req = '{idx: pool[3'($urandom())], counter: counterT'($urandom())};
            nextCycle();
        end
        lookupValid = 1'b0;
        upd0Valid = 1'b0;
        upd1Valid = 1'b0;
        endTest();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        lookupValid = 1'b0;
        lookupReq = '0;
        upd0Valid = 1'b0;
        upd1Valid = 1'b0;
        upd0Req = '0;
        upd1Req = '0;
        checks = 0;
        errors = 0;
        aborted = 1'b0;
        testName = "reset";
        void'($urandom(32'h96d7b5ba));
        clearedAfterInit();
        if (!aborted) singleUpdates();
        if (!aborted) pairedUpdates(1'b0, 8);
        if (!aborted) pairedUpdates(1'b1, 8);
        if (!aborted) randomMix();
        $display("checks %0d, mismatches %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: files.f
source/ghtPkg.sv
source/counterBank.sv
source/lookupStage.sv
source/updateScheduler.sv
source/ghtTop.sv
verif/ghtTop_sva.sv
verif/ghtTopTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module ghtTopTb -Mdir obj_dir -o simGht
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/simGht)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
